// File: rtl/irq_pkg.sv
/*
 * Shared definitions for the AVR-class interrupt controller:
 * widths, vector numbers, register addresses, sense modes,
 * sequencer states and the packed structs passed between stages.
 */
package irq_pkg;

    localparam int VEC_W     = 5;           // Vector number width
    localparam int NUM_VEC   = 26;          // Pending vector width, vector 0 is reset
    localparam int PC_W      = 16;          // Program counter width
    localparam int IO_ADDR_W = 8;           // Data-space address width
    localparam int IO_DATA_W = 8;           // I/O data width

    // Bit positions inside TIFR0/TIMSK0, as on the ATmega328P
    localparam int T0_OVF_BIT   = 0;        // TOV0 / TOIE0
    localparam int T0_COMPA_BIT = 1;        // OCF0A / OCIE0A
    localparam int T0_COMPB_BIT = 2;        // OCF0B / OCIE0B

    // Lowest number has the highest priority
    typedef enum logic [VEC_W-1:0] {
        VEC_NONE     = 5'd0,                // No request, shares slot with reset
        VEC_INT0     = 5'd1,
        VEC_INT1     = 5'd2,
        VEC_WDT      = 5'd6,
        VEC_T0_COMPA = 5'd14,
        VEC_T0_COMPB = 5'd15,
        VEC_T0_OVF   = 5'd16,
        VEC_SPI_STC  = 5'd17,
        VEC_USART_RX = 5'd18,
        VEC_ADC      = 5'd21,
        VEC_EE_READY = 5'd22
    } irq_vec_e;

    typedef enum logic [IO_ADDR_W-1:0] {
        TIFR0  = 8'h35,                     // Timer0 flags, write one to clear
        EIFR   = 8'h3C,                     // External flags, write one to clear
        EIMSK  = 8'h3D,                     // External masks
        EICRA  = 8'h69,                     // Sense control, 2 bits per pin
        TIMSK0 = 8'h6E                      // Timer0 masks
    } reg_addr_e;

    typedef enum logic [1:0] {
        SENSE_LOW  = 2'd0,                  // Level, repeats while low
        SENSE_ANY  = 2'd1,
        SENSE_FALL = 2'd2,
        SENSE_RISE = 2'd3
    } sense_mode_e;

    typedef enum logic {
        IDLE,
        IN_SERVICE                          // Between acknowledge and return
    } seq_state_e;

    typedef struct packed {
        logic [IO_ADDR_W-1:0] addr;
        logic [IO_DATA_W-1:0] wdata;
        logic                 read;         // Level, selects io_rdata
        logic                 write;        // Takes effect at the edge
    } io_bus_t;

    typedef struct packed {
        logic compb;
        logic compa;
        logic ovf;                          // Bit 0, same order as TIFR0
    } timer0_ev_t;

    typedef struct packed {
        logic wdt;
        logic spi_stc;
        logic usart_rx;
        logic adc;
        logic ee_ready;
    } periph_lvl_t;

    typedef struct packed {
        logic [2:0] tifr0;                  // OCF0B, OCF0A, TOV0
        logic [1:0] eifr;                   // INTF1, INTF0
    } irq_flags_t;

    typedef struct packed {
        logic [2:0] timsk0;                 // Same layout as tifr0
        logic [1:0] eimsk;
    } irq_masks_t;

endpackage

// File: rtl/ext_int_sense.sv
/*
 * INT0/INT1 pin sensing. Samples both pins and turns each into a
 * one-cycle event per its EICRA mode (low, any, fall, rise).
 */
`timescale 1ns/100ps

module ext_int_sense (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic [1:0]                int_pins,     // Asynchronous pins
    input  irq_pkg::sense_mode_e [1:0] eicra_modes, // Index 0 is INT0
    output logic [1:0]                ext_event     // Registered, one per pin
);
    import irq_pkg::*;

    logic [1:0] pin_s;                              // Sampled pin level
    logic [1:0] pin_prev;                           // Previous sample
    logic [1:0] event_d;

    // Event decode from current and previous sample
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            case (eicra_modes[i])
                SENSE_LOW:  event_d[i] = ~pin_s[i];
                SENSE_ANY:  event_d[i] = pin_s[i] ^ pin_prev[i];
                SENSE_FALL: event_d[i] = ~pin_s[i] & pin_prev[i];
                SENSE_RISE: event_d[i] = pin_s[i] & ~pin_prev[i];
                default:    event_d[i] = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pin_s     <= 2'b11;                     // Idle high, no false fall
            pin_prev  <= 2'b11;
            ext_event <= 2'b00;
        end else begin
            pin_s     <= int_pins;
            pin_prev  <= pin_s;
            ext_event <= event_d;                   // Event one edge after sample
        end
    end

endmodule

// File: rtl/irq_regs.sv
/*
 * Interrupt I/O registers: EIMSK, EICRA, TIMSK0, EIFR and TIFR0.
 * Flags are set by events, cleared by write-one or by acknowledge;
 * also holds the combinational read mux.
 */
`timescale 1ns/100ps

module irq_regs (
    input  logic                       clk,
    input  logic                       reset_n,
    input  irq_pkg::io_bus_t           io,
    output logic [irq_pkg::IO_DATA_W-1:0] io_rdata,
    input  logic [1:0]                 ext_event,
    input  irq_pkg::timer0_ev_t        t0_ev,
    input  logic                       ack_strobe,
    input  irq_pkg::irq_vec_e          ack_vec,
    output irq_pkg::sense_mode_e [1:0] eicra_modes,
    output irq_pkg::irq_flags_t        flags,
    output irq_pkg::irq_masks_t        masks
);
    import irq_pkg::*;

    logic [3:0] eicra_q;                        // ISC11..ISC00, upper bits unimplemented
    timer0_ev_t t0_q;                           // Timer pulses, one stage
    logic [1:0] eifr_clr;
    logic [2:0] tifr_clr;
    logic [2:0] tifr_set;

    assign eicra_modes[0] = sense_mode_e'(eicra_q[1:0]);
    assign eicra_modes[1] = sense_mode_e'(eicra_q[3:2]);

    // Map Timer0 pulses onto TIFR0 bit positions
    always_comb begin
        tifr_set               = '0;
        tifr_set[T0_OVF_BIT]   = t0_q.ovf;
        tifr_set[T0_COMPA_BIT] = t0_q.compa;
        tifr_set[T0_COMPB_BIT] = t0_q.compb;
    end

    // Clear terms from write-one and from the CPU acknowledge
    always_comb begin
        eifr_clr = '0;
        tifr_clr = '0;
        if (io.write && io.addr == EIFR)
            eifr_clr = io.wdata[1:0];
        if (io.write && io.addr == TIFR0)
            tifr_clr = io.wdata[2:0];
        if (ack_strobe) begin
            case (ack_vec)
                VEC_INT0:     eifr_clr[0] = 1'b1;
                VEC_INT1:     eifr_clr[1] = 1'b1;
                VEC_T0_OVF:   tifr_clr[T0_OVF_BIT] = 1'b1;
                VEC_T0_COMPA: tifr_clr[T0_COMPA_BIT] = 1'b1;
                VEC_T0_COMPB: tifr_clr[T0_COMPB_BIT] = 1'b1;
                default: ;                      // Level sources have no flag
            endcase
        end
    end

    // Control registers
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            masks   <= '0;
            eicra_q <= '0;
        end else if (io.write) begin
            case (io.addr)
                EIMSK:   masks.eimsk <= io.wdata[1:0];
                TIMSK0:  masks.timsk0 <= io.wdata[2:0];
                EICRA:   eicra_q <= io.wdata[3:0];
                default: ;
            endcase
        end
    end

    // Flags, set wins over clear
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            t0_q  <= '0;
            flags <= '0;
        end else begin
            t0_q        <= t0_ev;
            flags.eifr  <= (flags.eifr & ~eifr_clr) | ext_event;
            flags.tifr0 <= (flags.tifr0 & ~tifr_clr) | tifr_set;
        end
    end

    // Read mux, zero when idle or unknown address
    always_comb begin
        io_rdata = '0;
        if (io.read) begin
            case (io.addr)
                EIFR:    io_rdata = IO_DATA_W'(flags.eifr);
                EIMSK:   io_rdata = IO_DATA_W'(masks.eimsk);
                TIFR0:   io_rdata = IO_DATA_W'(flags.tifr0);
                TIMSK0:  io_rdata = IO_DATA_W'(masks.timsk0);
                EICRA:   io_rdata = IO_DATA_W'(eicra_q);
                default: io_rdata = '0;
            endcase
        end
    end

endmodule

// File: rtl/irq_arbiter.sv
/*
 * Priority arbiter. Builds the pending vector from masked flags and
 * peripheral levels and registers the lowest pending vector number.
 */
`timescale 1ns/100ps

module irq_arbiter (
    input  logic                 clk,
    input  logic                 reset_n,
    input  irq_pkg::irq_flags_t  flags,
    input  irq_pkg::irq_masks_t  masks,
    input  irq_pkg::periph_lvl_t periph,
    output irq_pkg::irq_vec_e    best_vec,
    output logic                 best_valid
);
    import irq_pkg::*;

    logic [NUM_VEC-1:0] pending;                // One bit per vector number
    irq_vec_e           sel_vec;
    logic               sel_valid;

    always_comb begin
        pending = '0;
        pending[VEC_INT0]     = flags.eifr[0] & masks.eimsk[0];
        pending[VEC_INT1]     = flags.eifr[1] & masks.eimsk[1];
        pending[VEC_WDT]      = periph.wdt;
        pending[VEC_T0_COMPA] = flags.tifr0[T0_COMPA_BIT] & masks.timsk0[T0_COMPA_BIT];
        pending[VEC_T0_COMPB] = flags.tifr0[T0_COMPB_BIT] & masks.timsk0[T0_COMPB_BIT];
        pending[VEC_T0_OVF]   = flags.tifr0[T0_OVF_BIT] & masks.timsk0[T0_OVF_BIT];
        pending[VEC_SPI_STC]  = periph.spi_stc;
        pending[VEC_USART_RX] = periph.usart_rx;
        pending[VEC_ADC]      = periph.adc;
        pending[VEC_EE_READY] = periph.ee_ready;
    end

    // Scan downward so the lowest set number is kept last
    always_comb begin
        sel_vec   = VEC_NONE;
        sel_valid = 1'b0;
        for (int i = NUM_VEC - 1; i >= 1; i--) begin
            if (pending[i]) begin
                sel_vec   = irq_vec_e'(VEC_W'(i));
                sel_valid = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            best_vec   <= VEC_NONE;
            best_valid <= 1'b0;
        end else begin
            best_vec   <= sel_vec;                  // One edge behind the flags
            best_valid <= sel_valid;
        end
    end

endmodule

// File: rtl/irq_sequencer.sv
/*
 * CPU-side sequencer. Raises the request in IDLE, moves to
 * IN_SERVICE on acknowledge and back on return; forms the vector
 * address and the acknowledge strobe toward the flag registers.
 */
`timescale 1ns/100ps

module irq_sequencer (
    input  logic                       clk,
    input  logic                       reset_n,
    input  irq_pkg::irq_vec_e          best_vec,
    input  logic                       best_valid,
    input  logic                       i_flag,        // Global enable from SREG
    input  logic                       irq_ack,       // Pulse
    input  logic                       irq_return,    // Pulse, RETI
    output logic                       irq_request,
    output irq_pkg::irq_vec_e          irq_vector,
    output logic [irq_pkg::PC_W-1:0]   pc_interrupt,
    output logic                       ack_strobe,
    output irq_pkg::irq_vec_e          ack_vec
);
    import irq_pkg::*;

    seq_state_e state;
    seq_state_e state_nxt;

    // Request follows arbiter and I flag combinationally, no hold
    assign irq_request = (state == IDLE) && i_flag && best_valid;
    assign irq_vector  = irq_request ? best_vec : VEC_NONE;

    // Word address of the vector table entry, 0 when idle
    assign pc_interrupt = PC_W'({irq_vector, 1'b0});

    // Acknowledge only counts while a request is shown
    assign ack_strobe = irq_ack && irq_request;
    assign ack_vec    = irq_vector;                    // Flag cleared at the ack edge

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (ack_strobe)
                    state_nxt = IN_SERVICE;
            end
            IN_SERVICE: begin
                if (irq_return)
                    state_nxt = IDLE;              // Next request may rise now
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= IDLE;
        else
            state <= state_nxt;
    end

endmodule

// File: rtl/axioma_irq_top.sv
/*
 * Interrupt controller top level. Chains pin sensing, flag
 * registers, arbitration and the CPU sequencer.
 */
`timescale 1ns/100ps

module axioma_irq_top (
    input  logic                          clk,
    input  logic                          reset_n,
    // CPU side
    input  logic                          i_flag,
    input  logic                          irq_ack,
    input  logic                          irq_return,
    output logic                          irq_request,
    output irq_pkg::irq_vec_e             irq_vector,
    output logic [irq_pkg::PC_W-1:0]      pc_interrupt,
    // Register bus
    input  irq_pkg::io_bus_t              io,
    output logic [irq_pkg::IO_DATA_W-1:0] io_rdata,
    // Interrupt sources
    input  logic [1:0]                    int_pins,
    input  irq_pkg::timer0_ev_t           t0_ev,
    input  irq_pkg::periph_lvl_t          periph
);
    import irq_pkg::*;

    logic [1:0]       ext_event;                    // INT0/INT1 events
    sense_mode_e [1:0] eicra_modes;
    irq_flags_t       flags;
    irq_masks_t       masks;
    irq_vec_e         best_vec;
    logic             best_valid;
    irq_vec_e         ack_vec;
    logic             ack_strobe;                   // Clears the served flag

    ext_int_sense u_sense (
        .clk         (clk),
        .reset_n     (reset_n),
        .int_pins    (int_pins),
        .eicra_modes (eicra_modes),
        .ext_event   (ext_event)
    );

    irq_regs u_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .io          (io),
        .io_rdata    (io_rdata),
        .ext_event   (ext_event),
        .t0_ev       (t0_ev),
        .ack_strobe  (ack_strobe),
        .ack_vec     (ack_vec),
        .eicra_modes (eicra_modes),
        .flags       (flags),
        .masks       (masks)
    );

    irq_arbiter u_arb (
        .clk        (clk),
        .reset_n    (reset_n),
        .flags      (flags),
        .masks      (masks),
        .periph     (periph),
        .best_vec   (best_vec),
        .best_valid (best_valid)
    );

    irq_sequencer u_seq (
        .clk          (clk),
        .reset_n      (reset_n),
        .best_vec     (best_vec),
        .best_valid   (best_valid),
        .i_flag       (i_flag),
        .irq_ack      (irq_ack),
        .irq_return   (irq_return),
        .irq_request  (irq_request),
        .irq_vector   (irq_vector),
        .pc_interrupt (pc_interrupt),
        .ack_strobe   (ack_strobe),
        .ack_vec      (ack_vec)
    );

endmodule

// File: verif/tb_clock_gen.sv
/*
 * Testbench clock and reset: 100 ns period, reset_n held low
 * for the first 8 rising edges.
 */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                     // 100 ns period
    end

    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clk);                  // 8 cycles in reset
        reset_n <= 1'b1;                            // Released on an edge
    end

endmodule

// File: verif/axioma_irq_chk.sv
/*
 * Concurrent checks on the CPU handshake of the interrupt
 * controller, attached to axioma_irq_top by bind.
 */
`timescale 1ns/100ps

module axioma_irq_chk (
    input logic                     clk,
    input logic                     reset_n,
    input logic                     i_flag,
    input logic                     irq_ack,
    input logic                     irq_return,
    input logic                     irq_request,
    input irq_pkg::irq_vec_e        irq_vector,
    input logic [irq_pkg::PC_W-1:0] pc_interrupt
);
    import irq_pkg::*;

    logic bad_iflag = 1'b0;                         // Sticky, one per property
    logic bad_pc = 1'b0;
    logic bad_service = 1'b0;
    logic bad_idle_vec = 1'b0;
    logic failed;                                   // Polled by the testbench
    logic in_service;                               // Accepted ack, no return yet

    assign failed = bad_iflag | bad_pc | bad_service | bad_idle_vec;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            in_service <= 1'b0;
        else if (irq_ack && irq_request)
            in_service <= 1'b1;
        else if (irq_return)
            in_service <= 1'b0;
    end

    a_req_iflag: assert property (@(posedge clk) disable iff (!reset_n)
        irq_request |-> i_flag)
        else begin
            $error("irq_request high while i_flag low");
            bad_iflag = 1'b1;
        end

    // Two words per vector table entry
    a_pc_addr: assert property (@(posedge clk) disable iff (!reset_n)
        irq_request |-> pc_interrupt == PC_W'(irq_vector) * PC_W'(2))
        else begin
            $error("pc_interrupt is not twice irq_vector");
            bad_pc = 1'b1;
        end

    a_no_req_serv: assert property (@(posedge clk) disable iff (!reset_n)
        in_service |-> !irq_request)
        else begin
            $error("irq_request between acknowledge and return");
            bad_service = 1'b1;
        end

    a_idle_vec: assert property (@(posedge clk) disable iff (!reset_n)
        !irq_request |-> irq_vector == VEC_NONE)
        else begin
            $error("irq_vector not VEC_NONE without a request");
            bad_idle_vec = 1'b1;
        end

endmodule

bind axioma_irq_top axioma_irq_chk u_chk (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_flag       (i_flag),
    .irq_ack      (irq_ack),
    .irq_return   (irq_return),
    .irq_request  (irq_request),
    .irq_vector   (irq_vector),
    .pc_interrupt (pc_interrupt)
);

// File: verif/axioma_irq_tb.sv
/*
 * Testbench top: DUT with a CPU model (acknowledge, return),
 * register access, INT0 sense modes, priority, gating and the
 * peripheral level sources. Random data from a Galois LFSR.
 */
`timescale 1ns/100ps

module axioma_irq_tb;
    import irq_pkg::*;

    logic                 clk;
    logic                 reset_n;
    logic                 i_flag;
    logic                 irq_ack;
    logic                 irq_return;
    logic                 irq_request;
    irq_vec_e             irq_vector;
    logic [PC_W-1:0]      pc_interrupt;
    io_bus_t              io;
    logic [IO_DATA_W-1:0] io_rdata;
    logic [1:0]           int_pins;
    timer0_ev_t           t0_ev;
    periph_lvl_t          periph;
    logic [31:0]          lfsr;                     // Galois LFSR state
    int                   wait_limit = 40;          // Cycles per bounded wait

    tb_clock_gen u_clk (.clk(clk), .reset_n(reset_n));

    axioma_irq_top dut0 (
        .clk(clk), .reset_n(reset_n), .i_flag(i_flag), .irq_ack(irq_ack),
        .irq_return(irq_return), .irq_request(irq_request), .irq_vector(irq_vector),
        .pc_interrupt(pc_interrupt), .io(io), .io_rdata(io_rdata),
        .int_pins(int_pins), .t0_ev(t0_ev), .periph(periph)
    );

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD000_0001) : (lfsr >> 1);
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic bus_write(input reg_addr_e addr, input logic [7:0] data);
        io_bus_t cmd;
        cmd       = '0;
        cmd.addr  = addr;
        cmd.wdata = data;
        cmd.write = 1'b1;
        @(posedge clk);
        io <= cmd;
        @(posedge clk);
        io <= '0;                                   // Write taken at this edge
    endtask

    task automatic bus_read(input reg_addr_e addr, output logic [7:0] data);
        io_bus_t cmd;
        cmd      = '0;
        cmd.addr = addr;
        cmd.read = 1'b1;
        @(posedge clk);
        io <= cmd;
        @(negedge clk);
        data = io_rdata;                            // Sampled mid-cycle after the mux settles
        @(posedge clk);
        io <= '0;
    endtask

    task automatic check_reg(input reg_addr_e addr, input logic [7:0] exp);
        logic [7:0] got;
        bus_read(addr, got);
        assert (got == exp) else
            abort_run($sformatf("MISMATCH io_rdata %s: got 0x%02h expected 0x%02h",
                                addr.name(), got, exp));
    endtask

    // Read a flag register until all given bits are set
    task automatic poll_set(input reg_addr_e addr, input logic [7:0] bits);
        logic [7:0] got;
        int n;
        got = '0;
        for (n = 0; n < wait_limit && (got & bits) != bits; n++)
            bus_read(addr, got);
        if ((got & bits) != bits)
            abort_run($sformatf("Timeout: %s bits 0x%02h never set", addr.name(), bits));
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!irq_request) else
                abort_run($sformatf("MISMATCH irq_request: got 0x1 expected 0x0 (vector 0x%02h)",
                                    irq_vector));
        end
    endtask

    // Wait for a request (or for a given vector), then check vector and address
    task automatic wait_request(input irq_vec_e exp, input bit match_only);
        logic [PC_W-1:0] exp_pc;
        int n;
        exp_pc = PC_W'(exp) * PC_W'(2);             // Two words per table entry
        n = 0;
        @(negedge clk);
        while (!(irq_request && (!match_only || irq_vector == exp)) && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!irq_request)
            abort_run($sformatf("Timeout: no irq_request for vector %0d", exp));
        assert (irq_vector == exp) else
            abort_run($sformatf("MISMATCH irq_vector: got 0x%02h expected 0x%02h",
                                irq_vector, exp));
        assert (pc_interrupt == exp_pc) else
            abort_run($sformatf("MISMATCH pc_interrupt: got 0x%04h expected 0x%04h",
                                pc_interrupt, exp_pc));
    endtask

    task automatic cpu_ack();
        @(posedge clk);
        irq_ack <= 1'b1;                            // One cycle after the request
        @(posedge clk);
        irq_ack <= 1'b0;
    endtask

    task automatic cpu_return();
        @(posedge clk);
        irq_return <= 1'b1;
        @(posedge clk);
        irq_return <= 1'b0;
    endtask

    task automatic t0_pulse(input timer0_ev_t ev);
        @(posedge clk);
        t0_ev <= ev;
        @(posedge clk);
        t0_ev <= '0;
    endtask

    // INT0 pin moves from_lvl to to_lvl under the given mode while INT1 senses falls
    task automatic sense_check(input sense_mode_e mode, input logic from_lvl,
                               input logic to_lvl, input bit expect_set);
        @(posedge clk);
        int_pins[0] <= from_lvl;
        bus_write(EICRA, {4'h0, SENSE_FALL, mode});
        idle(4);                                    // Let old events drain
        bus_write(EIFR, 8'h01);
        check_reg(EIFR, 8'h00);
        @(posedge clk);
        int_pins[0] <= to_lvl;
        if (expect_set)
            poll_set(EIFR, 8'h01);
        else
            repeat (6) check_reg(EIFR, 8'h00);
    endtask

    // Watch the bound checker every cycle
    always @(negedge clk) begin
        if (dut0.u_chk.failed)
            abort_run("Concurrent assertion failed in the checker");
    end

    initial begin
        logic [7:0] wdata;
        int n;
        lfsr       = 32'h14e9_ee1d;
        i_flag     = 1'b0;
        irq_ack    = 1'b0;
        irq_return = 1'b0;
        io         = '0;
        int_pins   = 2'b11;                         // Pins idle high
        t0_ev      = '0;
        periph     = '0;
        for (n = 0; n < wait_limit && reset_n !== 1'b1; n++)
            @(posedge clk);
        if (reset_n !== 1'b1)
            abort_run("Timeout: reset_n never released");

        // Reset values, then random mask and sense writes
        check_reg(EIFR, 8'h00);
        check_reg(EIMSK, 8'h00);
        check_reg(TIFR0, 8'h00);
        check_reg(EICRA, 8'h00);
        check_reg(TIMSK0, 8'h00);
        repeat (4) begin
            wdata = 8'(rand_bits(8));
            bus_write(EIMSK, wdata);
            check_reg(EIMSK, wdata & 8'h03);        // Two implemented bits
            wdata = 8'(rand_bits(8));
            bus_write(EICRA, wdata);
            check_reg(EICRA, wdata & 8'h0F);
            wdata = 8'(rand_bits(8));
            bus_write(TIMSK0, wdata);
            check_reg(TIMSK0, wdata & 8'h07);
            idle(rand_bits(2));
        end

        // Write-one-clear on TIFR0 and EIFR
        t0_pulse(timer0_ev_t'(3'b111));
        poll_set(TIFR0, 8'h07);
        wdata = 8'(rand_bits(3));
        bus_write(TIFR0, wdata);
        check_reg(TIFR0, 8'h07 & ~wdata);
        bus_write(TIFR0, 8'h07);
        check_reg(TIFR0, 8'h00);
        bus_write(EICRA, 8'h00);                    // Both pins low-level sense
        @(posedge clk);
        int_pins <= 2'b00;
        @(posedge clk);
        int_pins <= 2'b11;
        poll_set(EIFR, 8'h03);
        idle(2);
        wdata = 8'(rand_bits(2));
        bus_write(EIFR, wdata);
        check_reg(EIFR, 8'h03 & ~wdata);
        bus_write(EIFR, 8'h03);
        check_reg(EIFR, 8'h00);

        // INT0 sense modes
        sense_check(SENSE_FALL, 1'b1, 1'b0, 1'b1);
        sense_check(SENSE_FALL, 1'b0, 1'b1, 1'b0);
        sense_check(SENSE_RISE, 1'b0, 1'b1, 1'b1);
        sense_check(SENSE_RISE, 1'b1, 1'b0, 1'b0);
        sense_check(SENSE_LOW, 1'b1, 1'b0, 1'b1);
        sense_check(SENSE_LOW, 1'b1, 1'b1, 1'b0);
        sense_check(SENSE_ANY, 1'b1, 1'b0, 1'b1);
        sense_check(SENSE_ANY, 1'b0, 1'b1, 1'b1);

        // INT1 beats Timer0 overflow
        bus_write(EICRA, {4'h0, SENSE_FALL, SENSE_FALL});
        bus_write(EIFR, 8'h03);
        bus_write(TIFR0, 8'h07);
        bus_write(EIMSK, 8'h02);
        bus_write(TIMSK0, 8'h01);
        @(posedge clk);
        int_pins[1] <= 1'b0;
        t0_pulse(timer0_ev_t'(3'b001));
        poll_set(EIFR, 8'h02);
        poll_set(TIFR0, 8'h01);
        expect_quiet(4);                            // I flag still clear
        @(posedge clk);
        i_flag <= 1'b1;
        wait_request(VEC_INT1, 1'b0);

        // Acknowledge and return, then the overflow
        cpu_ack();
        check_reg(EIFR, 8'h00);
        expect_quiet(6);
        idle(rand_bits(2));
        cpu_return();
        wait_request(VEC_T0_OVF, 1'b0);
        cpu_ack();
        check_reg(TIFR0, 8'h00);
        expect_quiet(4);
        cpu_return();
        expect_quiet(4);

        // Gating by the I flag and by the mask
        @(posedge clk);
        i_flag <= 1'b0;
        bus_write(TIMSK0, 8'h02);
        t0_pulse(timer0_ev_t'(3'b010));
        poll_set(TIFR0, 8'h02);
        expect_quiet(wait_limit);
        check_reg(TIFR0, 8'h02);
        bus_write(TIFR0, 8'h02);
        check_reg(TIFR0, 8'h00);
        @(posedge clk);
        i_flag <= 1'b1;
        t0_pulse(timer0_ev_t'(3'b100));             // Compare B with its mask clear
        poll_set(TIFR0, 8'h04);
        expect_quiet(wait_limit);
        check_reg(TIFR0, 8'h04);
        bus_write(TIFR0, 8'h04);

        // WDT level, then INT0 takes over
        @(posedge clk);
        periph.wdt <= 1'b1;
        wait_request(VEC_WDT, 1'b0);
        bus_write(EIMSK, 8'h01);
        @(posedge clk);
        int_pins[0] <= 1'b0;
        wait_request(VEC_INT0, 1'b1);
        cpu_ack();
        check_reg(EIFR, 8'h00);
        cpu_return();
        wait_request(VEC_WDT, 1'b0);
        cpu_ack();
        @(posedge clk);
        periph.wdt <= 1'b0;
        idle(2);
        cpu_return();
        expect_quiet(8);

        if (!dut0.u_chk.failed) begin
            $display("Test passed");
            $finish;
        end else begin
            abort_run("Concurrent assertion failed in the checker");
        end
    end

endmodule

// File: axioma_irq_top.f
rtl/irq_pkg.sv
rtl/ext_int_sense.sv
rtl/irq_regs.sv
rtl/irq_arbiter.sv
rtl/irq_sequencer.sv
rtl/axioma_irq_top.sv
verif/tb_clock_gen.sv
verif/axioma_irq_chk.sv
verif/axioma_irq_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the interrupt controller testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module axioma_irq_tb -f axioma_irq_top.f -o sim_tb

# Raised error limit lets the testbench see checker failures
./obj_dir/sim_tb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
